//--- design/dispatch_pkg.sv
package dispatch_pkg;

    // basic widths
    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int TAG_W    = 2;
    localparam int NUM_REGS = 32;
    localparam int NUM_FU   = 3;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // producer tags, 0 means the value is ready
    localparam tag_t TAG_READY  = 2'd0;
    localparam tag_t TAG_ALU    = 2'd1;
    localparam tag_t TAG_BRANCH = 2'd2;
    localparam tag_t TAG_LOAD   = 2'd3;

    // instruction field positions
    localparam int OPC_LSB = 0;
    localparam int OPC_W   = 7;
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int SIGN_BIT = WORD_W - 1;

    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LD_ST  = 2'd1,
        FU_BRANCH = 2'd2
    } fu_t;

    // major opcodes of the supported subset
    typedef enum logic [OPC_W-1:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

endpackage

//--- design/decode_if.sv
`timescale 1ns/1ps

interface decode_if import dispatch_pkg::*; ();

    logic     dec_valid;
    fu_t      fu;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    logic     reg_write;
    logic     is_branch;
    logic     is_lui;

    modport src (
        output dec_valid, fu, rd, rs1, rs2, imm, reg_write, is_branch, is_lui
    );

    modport dst (
        input dec_valid, fu, rd, rs1, rs2, imm, reg_write, is_branch, is_lui
    );

endinterface

//--- design/status_if.sv
`timescale 1ns/1ps

interface status_if import dispatch_pkg::*; ();

    // dispatch write into the table
    logic     disp_write;
    reg_idx_t disp_reg;
    tag_t     disp_tag;
    logic     disp_spec;

    // lookups of the decoded registers
    tag_t     rs1_tag;
    tag_t     rs2_tag;
    logic     rd_busy;

    modport ctl (
        output disp_write, disp_reg, disp_tag, disp_spec,
        input  rs1_tag, rs2_tag, rd_busy
    );

    modport tbl (
        input  disp_write, disp_reg, disp_tag, disp_spec,
        output rs1_tag, rs2_tag, rd_busy
    );

endinterface

//--- design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import dispatch_pkg::*; (
    decode_if.src dec,
    input word_t  instr
);

    opcode_t  opcode;
    reg_idx_t rd_field;
    reg_idx_t rs1_field;
    reg_idx_t rs2_field;
    logic     writes_rd;
    logic     uses_rs1;
    logic     uses_rs2;

    assign opcode    = opcode_t'(instr[OPC_LSB +: OPC_W]);
    assign rd_field  = instr[RD_LSB +: REG_W];
    assign rs1_field = instr[RS1_LSB +: REG_W];
    assign rs2_field = instr[RS2_LSB +: REG_W];

    always_comb begin
        dec.dec_valid = 1'b1;
        dec.fu        = FU_ALU;
        dec.imm       = '0;
        dec.is_branch = 1'b0;
        dec.is_lui    = 1'b0;
        writes_rd     = 1'b0;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;

        case (opcode)
            OP_REG: begin
                writes_rd = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            OP_IMM: begin
                writes_rd = 1'b1;
                uses_rs1  = 1'b1;
                dec.imm   = {{20{instr[SIGN_BIT]}}, instr[31:20]};
            end
            OP_LUI: begin
                // lui runs on the alu as imm + 0
                writes_rd  = 1'b1;
                dec.is_lui = 1'b1;
                dec.imm    = {instr[31:12], 12'b0};
            end
            OP_LOAD: begin
                dec.fu    = FU_LD_ST;
                writes_rd = 1'b1;
                uses_rs1  = 1'b1;
                dec.imm   = {{20{instr[SIGN_BIT]}}, instr[31:20]};
            end
            OP_STORE: begin
                dec.fu   = FU_LD_ST;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                dec.imm  = {{20{instr[SIGN_BIT]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                dec.fu        = FU_BRANCH;
                dec.is_branch = 1'b1;
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.imm = {{19{instr[SIGN_BIT]}}, instr[31], instr[7],
                           instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                // unconditional, so no speculation, but it owns rd
                dec.fu    = FU_BRANCH;
                writes_rd = 1'b1;
                dec.imm = {{11{instr[SIGN_BIT]}}, instr[31], instr[19:12],
                           instr[20], instr[30:21], 1'b0};
            end
            default: dec.dec_valid = 1'b0;
        endcase
    end

    // x0 is never owned by anyone
    assign dec.reg_write = writes_rd && (rd_field != '0);
    assign dec.rd        = dec.reg_write ? rd_field : '0;
    assign dec.rs1       = uses_rs1 ? rs1_field : '0;
    assign dec.rs2       = uses_rs2 ? rs2_field : '0;

endmodule

//--- design/reg_status_table.sv
`timescale 1ns/1ps

module reg_status_table import dispatch_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    decode_if.dst    dec,
    status_if.tbl    st,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    input  tag_t     wb_tag,
    input  logic     branch_resolved,
    input  logic     branch_miss
);

    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] spec;
    tag_t                tag [NUM_REGS];
    logic [NUM_REGS-1:0] wb_hit;

    // writeback only frees the entry if the producer still matches
    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            wb_hit[i] = wb_en && (wb_reg == reg_idx_t'(i)) && (tag[i] == wb_tag);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            spec <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                tag[i] <= TAG_READY;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (wb_hit[i] || (branch_miss && spec[i])) begin
                    busy[i] <= 1'b0;
                    spec[i] <= 1'b0;
                    tag[i]  <= TAG_READY;
                end else if (branch_resolved) begin
                    spec[i] <= 1'b0;
                end
                // new owner wins over a same-cycle writeback
                if (st.disp_write && (st.disp_reg == reg_idx_t'(i))) begin
                    busy[i] <= 1'b1;
                    spec[i] <= st.disp_spec;
                    tag[i]  <= st.disp_tag;
                end
            end
        end
    end

    function automatic tag_t lookup(input reg_idx_t r);
        tag_t t;
        t = TAG_READY;
        if (busy[r] && !wb_hit[r]) begin
            t = tag[r];
        end
        return t;
    endfunction

    // combinational lookups with writeback bypass
    always_comb begin
        st.rs1_tag = lookup(dec.rs1);
        st.rs2_tag = lookup(dec.rs2);
        st.rd_busy = busy[dec.rd];
    end

endmodule

//--- design/dispatch_control.sv
`timescale 1ns/1ps

module dispatch_control import dispatch_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    decode_if.dst             dec,
    status_if.ctl             st,
    input  logic              instr_valid,
    input  logic [NUM_FU-1:0] fu_busy,
    input  logic              branch_resolved,
    input  logic              branch_miss,
    output logic              freeze,
    output logic              issue_en,
    output fu_t               issue_fu,
    output reg_idx_t          issue_rd,
    output reg_idx_t          issue_rs1,
    output reg_idx_t          issue_rs2,
    output word_t             issue_imm,
    output tag_t              issue_t1,
    output tag_t              issue_t2,
    output logic              issue_lui,
    output logic              issue_spec
);

    logic spec_q;
    logic present;
    logic hazard;
    logic issue;
    logic instr_spec;
    tag_t unit_tag;

    assign present = instr_valid && dec.dec_valid;

    // structural, waw and second unresolved branch
    assign hazard = fu_busy[dec.fu]
                  || (dec.reg_write && st.rd_busy)
                  || (dec.is_branch && spec_q);

    assign freeze = present && hazard;
    assign issue  = present && !hazard && !branch_miss;

    // an instruction is speculative only if the branch is still open after this cycle
    assign instr_spec = spec_q && !branch_resolved && !branch_miss;

    always_comb begin
        case (dec.fu)
            FU_LD_ST:  unit_tag = TAG_LOAD;
            FU_BRANCH: unit_tag = TAG_BRANCH;
            default:   unit_tag = TAG_ALU;
        endcase
    end

    assign st.disp_write = issue && dec.reg_write;
    assign st.disp_reg   = dec.rd;
    assign st.disp_tag   = unit_tag;
    assign st.disp_spec  = instr_spec;

    // miss beats a new branch, a new branch beats resolve
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec_q     <= 1'b0;
            issue_en   <= 1'b0;
            issue_spec <= 1'b0;
        end else begin
            if (branch_miss) begin
                spec_q <= 1'b0;
            end else if (issue && dec.is_branch) begin
                spec_q <= 1'b1;
            end else if (branch_resolved) begin
                spec_q <= 1'b0;
            end
            issue_en   <= issue;
            issue_spec <= issue && instr_spec;
        end
    end

    // issue payload
    always_ff @(posedge CLK) begin
        if (issue) begin
            issue_fu  <= dec.fu;
            issue_rd  <= dec.rd;
            issue_rs1 <= dec.rs1;
            issue_rs2 <= dec.rs2;
            issue_imm <= dec.imm;
            issue_t1  <= st.rs1_tag;
            issue_t2  <= st.rs2_tag;
            issue_lui <= dec.is_lui;
        end
    end

endmodule

//--- design/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage import dispatch_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    // from fetch
    input  word_t             instr,
    input  logic              instr_valid,
    output logic              freeze,
    // unit and writeback status
    input  logic [NUM_FU-1:0] fu_busy,
    input  logic              wb_en,
    input  reg_idx_t          wb_reg,
    input  tag_t              wb_tag,
    input  logic              branch_resolved,
    input  logic              branch_miss,
    // to issue
    output logic              issue_en,
    output fu_t               issue_fu,
    output reg_idx_t          issue_rd,
    output reg_idx_t          issue_rs1,
    output reg_idx_t          issue_rs2,
    output word_t             issue_imm,
    output tag_t              issue_t1,
    output tag_t              issue_t2,
    output logic              issue_lui,
    output logic              issue_spec
);

    decode_if dec ();
    status_if st ();

    instr_decoder u_decoder (
        .dec   (dec.src),
        .instr (instr)
    );

    reg_status_table u_rst (
        .CLK             (CLK),
        .nRST            (nRST),
        .dec             (dec.dst),
        .st              (st.tbl),
        .wb_en           (wb_en),
        .wb_reg          (wb_reg),
        .wb_tag          (wb_tag),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss)
    );

    dispatch_control u_ctrl (
        .CLK             (CLK),
        .nRST            (nRST),
        .dec             (dec.dst),
        .st              (st.ctl),
        .instr_valid     (instr_valid),
        .fu_busy         (fu_busy),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .freeze          (freeze),
        .issue_en        (issue_en),
        .issue_fu        (issue_fu),
        .issue_rd        (issue_rd),
        .issue_rs1       (issue_rs1),
        .issue_rs2       (issue_rs2),
        .issue_imm       (issue_imm),
        .issue_t1        (issue_t1),
        .issue_t2        (issue_t2),
        .issue_lui       (issue_lui),
        .issue_spec      (issue_spec)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // reset held over the first four rising edges
    initial begin
        nRST = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

//--- dv/dispatch_properties.sv
`timescale 1ns/1ps

module dispatch_properties import dispatch_pkg::*; (
    input logic  CLK,
    input logic  nRST,
    input word_t instr,
    input logic  instr_valid,
    input logic  freeze,
    input logic  branch_miss,
    input logic  issue_en,
    input logic  issue_spec
);

    logic new_branch;
    logic after_miss;

    // a conditional branch leaving dispatch this cycle
    assign new_branch = instr_valid && !freeze && !branch_miss
                      && (instr[OPC_LSB +: OPC_W] == OP_BRANCH);

    // set by a miss, cleared once another branch goes out
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            after_miss <= 1'b0;
        end else if (branch_miss) begin
            after_miss <= 1'b1;
        end else if (new_branch) begin
            after_miss <= 1'b0;
        end
    end

    issue_idle_in_reset: assert property (@(posedge CLK) !nRST |-> !issue_en)
        else $error("issue_en high while reset is asserted");

    no_issue_after_freeze: assert property (
        @(posedge CLK) disable iff (!nRST) freeze |=> !issue_en)
        else $error("instruction issued in a frozen cycle");

    no_issue_after_miss: assert property (
        @(posedge CLK) disable iff (!nRST) branch_miss |=> !issue_en)
        else $error("instruction issued in a branch miss cycle");

    no_spec_after_miss: assert property (
        @(posedge CLK) disable iff (!nRST) after_miss |=> !issue_spec)
        else $error("issue_spec set with no open branch after a miss");

endmodule

bind dispatch_stage dispatch_properties u_props (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr       (instr),
    .instr_valid (instr_valid),
    .freeze      (freeze),
    .branch_miss (branch_miss),
    .issue_en    (issue_en),
    .issue_spec  (issue_spec)
);

//--- dv/dispatch_tb.sv
`timescale 1ns/1ps

module dispatch_tb import dispatch_pkg::*; ();

    localparam int NUM_FIELDS    = 19;
    localparam int MAX_VECTORS   = 64;
    localparam int RESET_TIMEOUT = 20;

    logic              CLK;
    logic              nRST;
    word_t             instr;
    logic              instr_valid;
    logic              freeze;
    logic [NUM_FU-1:0] fu_busy;
    logic              wb_en;
    reg_idx_t          wb_reg;
    tag_t              wb_tag;
    logic              branch_resolved;
    logic              branch_miss;
    logic              issue_en;
    fu_t               issue_fu;
    reg_idx_t          issue_rd;
    reg_idx_t          issue_rs1;
    reg_idx_t          issue_rs2;
    word_t             issue_imm;
    tag_t              issue_t1;
    tag_t              issue_t2;
    logic              issue_lui;
    logic              issue_spec;

    logic [31:0] vec_mem [NUM_FIELDS*MAX_VECTORS];
    int          num_vectors;
    int          vec_errors;
    int          pass_count;
    int          fail_count;
    int          wait_cycles;

    tb_clock_gen u_clk (
        .CLK  (CLK),
        .nRST (nRST)
    );

    dispatch_stage DUT (.*);

    // funct3 and funct7 bits mean nothing to this stage
    function automatic word_t fill_dont_care(input word_t w);
        word_t       r;
        logic [31:0] rnd;
        r   = w;
        rnd = $urandom();
        case (w[OPC_LSB +: OPC_W])
            OP_REG: begin
                r[14:12] = rnd[2:0];
                r[31:25] = rnd[9:3];
            end
            OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH: begin
                r[14:12] = rnd[2:0];
            end
            default: begin
            end
        endcase
        return r;
    endfunction

    task automatic report_mismatch(input int n, input string what,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("mismatch at %0t: vector %0d %s is %0h, expected %0h",
                 $time, n, what, got, exp);
        vec_errors++;
    endtask

    // one vector is one cycle: drive, check freeze, then the issue outputs
    task automatic run_vector(input int n);
        logic [31:0] f [NUM_FIELDS];
        for (int k = 0; k < NUM_FIELDS; k++) begin
            f[k] = vec_mem[n*NUM_FIELDS + k];
        end
        vec_errors = 0;
        @(negedge CLK);
        instr_valid     = f[0][0];
        instr           = fill_dont_care(f[1]);
        fu_busy         = f[2][NUM_FU-1:0];
        wb_en           = f[3][0];
        wb_reg          = f[4][REG_W-1:0];
        wb_tag          = f[5][TAG_W-1:0];
        branch_resolved = f[6][0];
        branch_miss     = f[7][0];
        #1;
        if (freeze !== f[8][0])
            report_mismatch(n, "freeze", 32'(freeze), f[8]);
        @(posedge CLK);
        #1;
        if (issue_en !== f[9][0])
            report_mismatch(n, "issue_en", 32'(issue_en), f[9]);
        if (issue_spec !== f[18][0])
            report_mismatch(n, "issue_spec", 32'(issue_spec), f[18]);
        // payload is only meaningful on an issue
        if (f[9][0]) begin
            if (issue_fu !== f[10][1:0])
                report_mismatch(n, "issue_fu", 32'(issue_fu), f[10]);
            if (issue_rd !== f[11][REG_W-1:0])
                report_mismatch(n, "issue_rd", 32'(issue_rd), f[11]);
            if (issue_rs1 !== f[12][REG_W-1:0])
                report_mismatch(n, "issue_rs1", 32'(issue_rs1), f[12]);
            if (issue_rs2 !== f[13][REG_W-1:0])
                report_mismatch(n, "issue_rs2", 32'(issue_rs2), f[13]);
            if (issue_imm !== f[14])
                report_mismatch(n, "issue_imm", issue_imm, f[14]);
            if (issue_t1 !== f[15][TAG_W-1:0])
                report_mismatch(n, "issue_t1", 32'(issue_t1), f[15]);
            if (issue_t2 !== f[16][TAG_W-1:0])
                report_mismatch(n, "issue_t2", 32'(issue_t2), f[16]);
            if (issue_lui !== f[17][0])
                report_mismatch(n, "issue_lui", 32'(issue_lui), f[17]);
        end
        if (vec_errors == 0) begin
            pass_count++;
            $display("vector %0d: pass", n);
        end else begin
            fail_count++;
            $display("vector %0d: fail with %0d wrong outputs", n, vec_errors);
        end
    endtask

    initial begin
        void'($urandom(32'h3302_9603));
        instr           = '0;
        instr_valid     = 1'b0;
        fu_busy         = '0;
        wb_en           = 1'b0;
        wb_reg          = '0;
        wb_tag          = TAG_READY;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        pass_count      = 0;
        fail_count      = 0;
        for (int i = 0; i < NUM_FIELDS*MAX_VECTORS; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("dv/dispatch_tests.txt", vec_mem);
        // first field is instr_valid, so anything above 1 is unused memory
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && vec_mem[num_vectors*NUM_FIELDS] <= 32'd1) begin
            num_vectors++;
        end

        wait_cycles = 0;
        while (nRST !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge CLK);
            wait_cycles++;
        end
        if (nRST !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Simulation FAILED");
            $finish;
        end else begin
            for (int n = 0; n < num_vectors; n++) begin
                run_vector(n);
            end
            if (num_vectors == 0) begin
                $display("no test vectors were read from dv/dispatch_tests.txt");
            end
            $display("%0d vectors run, %0d passed, %0d failed",
                     num_vectors, pass_count, fail_count);
            if (fail_count == 0 && num_vectors > 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

//--- dv/dispatch_tests.txt
// valid instr fu_busy wb_en wb_reg wb_tag resolved miss, then expected:
// freeze issue_en fu rd rs1 rs2 imm t1 t2 lui spec (payload checked only when issue_en is 1)
// decode and issue from a clean table: add, addi, lui, lw, sw, jal
1 003100B3 0 0 00 0 0 0  0 1 0 01 02 03 00000000 0 0 0 0
1 FFD28213 0 0 00 0 0 0  0 1 0 04 05 00 FFFFFFFD 0 0 0 0
1 12345337 0 0 00 0 0 0  0 1 0 06 00 00 12345000 0 0 1 0
1 01040383 0 0 00 0 0 0  0 1 1 07 08 00 00000010 0 0 0 0
1 FE950C23 0 0 00 0 0 0  0 1 1 00 0A 09 FFFFFFF8 0 0 0 0
1 100005EF 0 0 00 0 0 0  0 1 2 0B 00 00 00000100 0 0 0 0
// tag forwarding, then bypass of a same-cycle writeback of x7
1 00708633 0 0 00 0 0 0  0 1 0 0C 01 07 00000000 1 3 0 0
1 001386B3 0 1 07 3 0 0  0 1 0 0D 07 01 00000000 0 1 0 0
// busy alu, then waw on x1 with a mismatched and a matching writeback
1 00508713 1 0 00 0 0 0  1 0 0 00 00 00 00000000 0 0 0 0
1 00508713 0 0 00 0 0 0  0 1 0 0E 01 00 00000005 1 0 0 0
1 00100093 0 0 00 0 0 0  1 0 0 00 00 00 00000000 0 0 0 0
1 00100093 0 1 01 3 0 0  1 0 0 00 00 00 00000000 0 0 0 0
1 00100093 0 0 00 0 0 0  1 0 0 00 00 00 00000000 0 0 0 0
1 00100093 0 1 01 1 0 0  1 0 0 00 00 00 00000000 0 0 0 0
1 00100093 0 0 00 0 0 0  0 1 0 01 00 00 00000001 0 0 0 0
// speculation after beq, second branch waits for resolve
1 00310863 0 0 00 0 0 0  0 1 2 00 02 03 00000010 0 0 0 0
1 00220793 0 0 00 0 0 0  0 1 0 0F 04 00 00000002 1 0 0 1
1 00628463 0 0 00 0 0 0  1 0 0 00 00 00 00000000 0 0 0 0
1 00628463 0 0 00 0 1 0  1 0 0 00 00 00 00000000 0 0 0 0
1 00628463 0 0 00 0 0 0  0 1 2 00 05 06 00000008 0 1 0 0
// miss rollback of x16, x15 keeps its tag
1 00700813 0 0 00 0 0 0  0 1 0 10 00 00 00000007 0 0 0 1
1 00F808B3 0 0 00 0 0 1  0 0 0 00 00 00 00000000 0 0 0 0
1 00F808B3 0 0 00 0 0 0  0 1 0 11 10 0F 00000000 0 1 0 0
// unknown opcode and an idle cycle
1 0000007F 7 0 00 0 0 0  0 0 0 00 00 00 00000000 0 0 0 0
0 00F808B3 0 0 00 0 0 0  0 0 0 00 00 00 00000000 0 0 0 0

//--- dispatch.f
design/dispatch_pkg.sv
design/decode_if.sv
design/status_if.sv
design/instr_decoder.sv
design/reg_status_table.sv
design/dispatch_control.sv
design/dispatch_stage.sv
dv/tb_clock_gen.sv
dv/dispatch_properties.sv
dv/dispatch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# run from the project root so the vector file path resolves
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dispatch_tb -f dispatch.f -o dispatch_sim \
    && ./obj_dir/dispatch_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
